// File: common/kd_trav_pkg.sv
/*
  shared types for the kd-tree traversal slice
  values are signed Q16.16 fixed point, no floating point or NaN
  N_LANES may be set from 2 to 8
  t_min >= 0 is assumed by the user and is not checked anywhere
*/
`default_nettype none

package kd_trav_pkg;

  // -------------------------------------------------------------------
  // fixed point
  // -------------------------------------------------------------------
  typedef logic signed [31:0] fix_t;

  // fraction bits
  localparam int   FIX_FRAC = 16;
  // saturation limits
  localparam fix_t FIX_MAX  = 32'sh7fff_ffff;
  localparam fix_t FIX_MIN  = 32'sh8000_0000;

  // -------------------------------------------------------------------
  // lanes and tags
  // -------------------------------------------------------------------
  typedef logic [3:0] tag_t;

  localparam int N_LANES = 4;
  localparam int LANE_W  = (N_LANES > 1) ? $clog2(N_LANES) : 1;

  typedef logic [LANE_W-1:0] lane_idx_t;

  // same encoding as the float version of the lane
  typedef enum logic [1:0] {
    ONLY_LOW   = 2'd0,
    ONLY_HIGH  = 2'd1,
    LO_THEN_HI = 2'd2,
    HI_THEN_LO = 2'd3
  } trav_case_e;

  // one node test, values on the split axis only
  typedef struct packed {
    tag_t tag;
    fix_t origin;
    fix_t dir;
    fix_t split;
    fix_t t_min;
    fix_t t_max;
  } trav_job_t;

  typedef struct packed {
    tag_t       tag;
    trav_case_e tcase;
    logic       dir_zero;
    fix_t       t_min;
    fix_t       t_max;
    fix_t       t_mid;
  } trav_res_t;

  // first set bit of mask at or after ptr, wrapping; ptr if mask is empty
  function automatic lane_idx_t rr_pick(input logic [N_LANES-1:0] mask,
                                        input lane_idx_t ptr);
    int        j;
    lane_idx_t pick;
    pick = ptr;
    // walk down so the closest lane wins
    for (int i = N_LANES - 1; i >= 0; i--) begin
      j = int'(ptr) + i;
      if (j >= N_LANES) j = j - N_LANES;
      if (mask[j]) pick = lane_idx_t'(j);
    end
    return pick;
  endfunction

  // wrap at N_LANES, also for counts that are not a power of two
  function automatic lane_idx_t rr_next(input lane_idx_t ptr);
    return (ptr == lane_idx_t'(N_LANES - 1)) ? '0 : ptr + 1'b1;
  endfunction

endpackage

`default_nettype wire

// File: trav_math/fix_div.sv
/*
  signed Q16.16 restoring divider, one quotient bit per clock
  start is taken only when idle; done pulses 32 cycles after start
  quotient truncates toward zero and saturates to FIX_MAX / FIX_MIN
  div_zero is valid with done; the quotient is then not meaningful
*/
`timescale 1ns/1ps
`default_nettype none

module fix_div (
  input  wire logic              clk,
  input  wire logic              arst_n,
  input  wire logic              start,
  input  kd_trav_pkg::fix_t      dividend,
  input  kd_trav_pkg::fix_t      divisor,
  output kd_trav_pkg::fix_t      quotient,
  output logic                   div_zero,
  output logic                   done
);

  localparam int W  = $bits(kd_trav_pkg::fix_t);
  localparam int NW = W + kd_trav_pkg::FIX_FRAC;

  logic [W-1:0]  mag_a;
  logic [W-1:0]  mag_b;
  logic [NW-1:0] num;

  // control
  logic          busy;
  logic [5:0]    cnt;

  // datapath, no reset
  logic [W-1:0]  rem;
  logic [W-1:0]  nlo;
  logic [W-1:0]  q;
  logic [W-1:0]  den;
  logic          neg;
  logic          ovf;

  logic [W:0]    rem_sh;
  logic          fits;
  logic [W:0]    rem_nx;

  // magnitudes, -2^31 maps to 2^31 which still fits unsigned
  always_comb begin
    mag_a = dividend[W-1] ? -dividend : dividend;
    mag_b = divisor[W-1] ? -divisor : divisor;
    num   = {mag_a, {kd_trav_pkg::FIX_FRAC{1'b0}}};
  end

  // one restoring step
  always_comb begin
    rem_sh = {rem, nlo[W-1]};
    fits   = (rem_sh >= {1'b0, den});
    rem_nx = fits ? rem_sh - {1'b0, den} : rem_sh;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!busy && start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == 6'(W - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && start) begin
      // top FIX_FRAC bits seed the remainder; quotient >= 2^32 if they already fit
      rem      <= {{(W - kd_trav_pkg::FIX_FRAC){1'b0}}, num[NW-1:W]};
      nlo      <= num[W-1:0];
      q        <= '0;
      den      <= mag_b;
      neg      <= dividend[W-1] ^ divisor[W-1];
      ovf      <= ({{(W - kd_trav_pkg::FIX_FRAC){1'b0}}, num[NW-1:W]} >= mag_b);
      div_zero <= (divisor == '0);
    end else if (busy) begin
      rem <= rem_nx[W-1:0];
      nlo <= {nlo[W-2:0], 1'b0};
      q   <= {q[W-2:0], fits};
    end
  end

  // sign and saturation; negative side reaches one step further
  always_comb begin
    if (!neg) begin
      quotient = (ovf || q[W-1]) ? kd_trav_pkg::FIX_MAX : $signed(q);
    end else if (ovf || (q > {1'b1, {(W-1){1'b0}}})) begin
      quotient = kd_trav_pkg::FIX_MIN;
    end else begin
      quotient = -$signed(q);
    end
  end

endmodule

`default_nettype wire

// File: trav_math/trav_math.sv
/*
  one traversal lane: t_mid = (split - origin) / dir and the case pick
  fixed latency, done_req rises 35 cycles after the job is captured
  split - origin saturates to the fix_t range before the divide
  dir = 0 gives dir_zero, t_mid = FIX_MAX and the near side only
  holds its result until done_ack, one job at a time
*/
`timescale 1ns/1ps
`default_nettype none

module trav_math (
  input  wire logic               clk,
  input  wire logic               arst_n,
  input  wire logic               lane_req,
  input  kd_trav_pkg::trav_job_t  lane_job,
  input  wire logic               done_ack,
  output logic                    lane_ack,
  output logic                    lane_idle,
  output logic                    done_req,
  output kd_trav_pkg::trav_res_t  done_res
);

  typedef enum logic [2:0] {S_IDLE, S_SUB, S_DIV, S_OUT, S_REL} state_e;

  state_e                  state;
  kd_trav_pkg::trav_job_t  job_r;

  logic signed [32:0]      diff_w;
  kd_trav_pkg::fix_t       diff_sat;
  kd_trav_pkg::fix_t       diff_r;
  logic                    near_lo;
  logic                    div_start;

  kd_trav_pkg::fix_t       quotient;
  logic                    div_zero;
  logic                    div_done;
  kd_trav_pkg::fix_t       t_mid;
  kd_trav_pkg::trav_case_e tcase;

  // -------------------------------------------------------------------
  // subtract
  // -------------------------------------------------------------------
  always_comb begin
    diff_w = {job_r.split[31], job_r.split} - {job_r.origin[31], job_r.origin};
    // clip on signed overflow
    if (diff_w[32] != diff_w[31]) begin
      diff_sat = diff_w[32] ? kd_trav_pkg::FIX_MIN : kd_trav_pkg::FIX_MAX;
    end else begin
      diff_sat = diff_w[31:0];
    end
  end

  fix_div u_div (
    .clk      (clk),
    .arst_n   (arst_n),
    .start    (div_start),
    .dividend (diff_r),
    .divisor  (job_r.dir),
    .quotient (quotient),
    .div_zero (div_zero),
    .done     (div_done)
  );

  // -------------------------------------------------------------------
  // classify, near side first
  // -------------------------------------------------------------------
  always_comb begin
    t_mid = div_zero ? kd_trav_pkg::FIX_MAX : quotient;
    if (div_zero || t_mid < 0 || t_mid >= job_r.t_max) begin
      // moving away or plane past the exit
      tcase = near_lo ? kd_trav_pkg::ONLY_LOW : kd_trav_pkg::ONLY_HIGH;
    end else if (t_mid <= job_r.t_min) begin
      // plane behind the entry point
      tcase = near_lo ? kd_trav_pkg::ONLY_HIGH : kd_trav_pkg::ONLY_LOW;
    end else begin
      tcase = near_lo ? kd_trav_pkg::LO_THEN_HI : kd_trav_pkg::HI_THEN_LO;
    end
  end

  // -------------------------------------------------------------------
  // lane sequencer, both handshakes
  // -------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= S_IDLE;
      lane_ack  <= 1'b0;
      lane_idle <= 1'b1;
      done_req  <= 1'b0;
      div_start <= 1'b0;
    end else begin
      div_start <= 1'b0;
      // input side closes on its own
      if (lane_ack && !lane_req) lane_ack <= 1'b0;
      case (state)
        S_IDLE: if (lane_req) begin
          lane_ack  <= 1'b1;
          lane_idle <= 1'b0;
          state     <= S_SUB;
        end
        S_SUB: begin
          div_start <= 1'b1;
          state     <= S_DIV;
        end
        S_DIV: if (div_done) begin
          done_req <= 1'b1;
          state    <= S_OUT;
        end
        S_OUT: if (done_ack) begin
          done_req <= 1'b0;
          state    <= S_REL;
        end
        // lane_ack drops on this same edge when lane_req is low
        S_REL: if (!done_ack && !lane_req) begin
          lane_idle <= 1'b1;
          state     <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (state == S_IDLE && lane_req) job_r <= lane_job;
    if (state == S_SUB) begin
      diff_r  <= diff_sat;
      // low is near when origin is below, or on the plane going down
      near_lo <= (job_r.origin < job_r.split) ||
                 ((job_r.origin == job_r.split) && (job_r.dir <= 0));
    end
    if (state == S_DIV && div_done) begin
      done_res.tag      <= job_r.tag;
      done_res.tcase    <= tcase;
      done_res.dir_zero <= div_zero;
      done_res.t_min    <= job_r.t_min;
      done_res.t_max    <= job_r.t_max;
      done_res.t_mid    <= t_mid;
    end
  end

endmodule

`default_nettype wire

// File: hdl/trav_dispatch.sv
/*
  job dispatcher, four-phase job port in, one lane request at a time out
  first idle lane at or after a rotating pointer gets the job
  job_ack waits for the lane, so a full set of lanes stalls the port
*/
`timescale 1ns/1ps
`default_nettype none

module trav_dispatch (
  input  wire logic                               clk,
  input  wire logic                               arst_n,
  input  wire logic                               job_req,
  input  kd_trav_pkg::trav_job_t                  job,
  input  wire logic [kd_trav_pkg::N_LANES-1:0]    lane_ack,
  input  wire logic [kd_trav_pkg::N_LANES-1:0]    lane_idle,
  output logic                                    job_ack,
  output logic [kd_trav_pkg::N_LANES-1:0]         lane_req,
  output kd_trav_pkg::trav_job_t                  lane_job
);

  typedef enum logic [1:0] {D_IDLE, D_LANE, D_ACK} dstate_e;

  dstate_e                state;
  kd_trav_pkg::lane_idx_t ptr;
  kd_trav_pkg::lane_idx_t sel;
  kd_trav_pkg::lane_idx_t pick;

  assign pick = kd_trav_pkg::rr_pick(lane_idle, ptr);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= D_IDLE;
      ptr      <= '0;
      sel      <= '0;
      job_ack  <= 1'b0;
      lane_req <= '0;
    end else begin
      case (state)
        // new job and somewhere to put it
        D_IDLE: if (job_req && |lane_idle) begin
          sel            <= pick;
          ptr            <= kd_trav_pkg::rr_next(pick);
          lane_req[pick] <= 1'b1;
          state          <= D_LANE;
        end
        // lane has the job, close toward lane and open toward source
        D_LANE: if (lane_ack[sel]) begin
          lane_req[sel] <= 1'b0;
          job_ack       <= 1'b1;
          state         <= D_ACK;
        end
        D_ACK: if (!job_req) begin
          job_ack <= 1'b0;
          state   <= D_IDLE;
        end
        default: state <= D_IDLE;
      endcase
    end
  end

  // copy kept so the source may move on after job_ack
  always_ff @(posedge clk) begin
    if (state == D_IDLE && job_req && |lane_idle) lane_job <= job;
  end

endmodule

`default_nettype wire

// File: hdl/trav_collect.sv
/*
  result collector, round-robin over lanes holding done_req
  one result in flight; the next lane is taken after res_ack falls
  results leave in completion order, the tag tells them apart
*/
`timescale 1ns/1ps
`default_nettype none

module trav_collect (
  input  wire logic                               clk,
  input  wire logic                               arst_n,
  input  wire logic [kd_trav_pkg::N_LANES-1:0]    done_req,
  input  kd_trav_pkg::trav_res_t                  done_res [kd_trav_pkg::N_LANES],
  input  wire logic                               res_ack,
  output logic [kd_trav_pkg::N_LANES-1:0]         done_ack,
  output logic                                    res_req,
  output kd_trav_pkg::trav_res_t                  res
);

  typedef enum logic [1:0] {C_IDLE, C_LOAD, C_OUT, C_REL} cstate_e;

  cstate_e                         state;
  kd_trav_pkg::lane_idx_t          ptr;
  kd_trav_pkg::lane_idx_t          pick;
  logic [kd_trav_pkg::N_LANES-1:0] pend;

  // lanes waiting that are not in an open handshake
  assign pend = done_req & ~done_ack;
  assign pick = kd_trav_pkg::rr_pick(pend, ptr);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= C_IDLE;
      ptr      <= '0;
      done_ack <= '0;
      res_req  <= 1'b0;
    end else begin
      // lane side closes once the lane drops its request
      for (int i = 0; i < kd_trav_pkg::N_LANES; i++) begin
        if (done_ack[i] && !done_req[i]) done_ack[i] <= 1'b0;
      end
      case (state)
        C_IDLE: if (|pend) begin
          done_ack[pick] <= 1'b1;
          ptr            <= kd_trav_pkg::rr_next(pick);
          state          <= C_LOAD;
        end
        // res is loaded, offer it
        C_LOAD: begin
          res_req <= 1'b1;
          state   <= C_OUT;
        end
        C_OUT: if (res_ack) begin
          res_req <= 1'b0;
          state   <= C_REL;
        end
        C_REL: if (!res_ack) state <= C_IDLE;
        default: state <= C_IDLE;
      endcase
    end
  end

  // result register, loaded with the grant
  always_ff @(posedge clk) begin
    if (state == C_IDLE && |pend) res <= done_res[pick];
  end

endmodule

`default_nettype wire

// File: hdl/kd_trav_top.sv
/*
  kd-tree traversal slice top level
  four-phase job port in, four-phase result port out
  N_LANES lanes work in parallel, so results may come back out of order
  the caller keeps tags unique while their jobs are in flight
*/
`timescale 1ns/1ps
`default_nettype none

module kd_trav_top (
  input  wire logic               clk,
  input  wire logic               arst_n,
  input  wire logic               job_req,
  input  kd_trav_pkg::trav_job_t  job,
  input  wire logic               res_ack,
  output logic                    job_ack,
  output logic                    res_req,
  output kd_trav_pkg::trav_res_t  res
);

  // dispatcher to lanes
  logic [kd_trav_pkg::N_LANES-1:0] lane_req;
  logic [kd_trav_pkg::N_LANES-1:0] lane_ack;
  logic [kd_trav_pkg::N_LANES-1:0] lane_idle;
  kd_trav_pkg::trav_job_t          lane_job;

  // lanes to collector
  logic [kd_trav_pkg::N_LANES-1:0] done_req;
  logic [kd_trav_pkg::N_LANES-1:0] done_ack;
  kd_trav_pkg::trav_res_t          done_res [kd_trav_pkg::N_LANES];

  trav_dispatch u_dispatch (
    .clk       (clk),
    .arst_n    (arst_n),
    .job_req   (job_req),
    .job       (job),
    .lane_ack  (lane_ack),
    .lane_idle (lane_idle),
    .job_ack   (job_ack),
    .lane_req  (lane_req),
    .lane_job  (lane_job)
  );

  // -------------------------------------------------------------------
  // lanes, shared job bus
  // -------------------------------------------------------------------
  for (genvar i = 0; i < kd_trav_pkg::N_LANES; i++) begin : g_lane
    trav_math u_lane (
      .clk       (clk),
      .arst_n    (arst_n),
      .lane_req  (lane_req[i]),
      .lane_job  (lane_job),
      .done_ack  (done_ack[i]),
      .lane_ack  (lane_ack[i]),
      .lane_idle (lane_idle[i]),
      .done_req  (done_req[i]),
      .done_res  (done_res[i])
    );
  end

  trav_collect u_collect (
    .clk      (clk),
    .arst_n   (arst_n),
    .done_req (done_req),
    .done_res (done_res),
    .res_ack  (res_ack),
    .done_ack (done_ack),
    .res_req  (res_req),
    .res      (res)
  );

endmodule

`default_nettype wire

// File: testbench/kd_trav_properties.sv
/*
  handshake rules on the top-level ports, bound into kd_trav_top
  fail_cnt counts the failed properties for the closing summary
  lane_req and lane_ack come from the dispatcher wiring inside the top
*/
`timescale 1ns/1ps
`default_nettype none

module kd_trav_props (
  input  wire logic                            clk,
  input  wire logic                            arst_n,
  input  wire logic                            job_req,
  input  wire logic                            job_ack,
  input  wire logic                            res_req,
  input  wire logic                            res_ack,
  input  kd_trav_pkg::trav_res_t               res,
  input  wire logic [kd_trav_pkg::N_LANES-1:0] lane_req,
  input  wire logic [kd_trav_pkg::N_LANES-1:0] lane_ack
);

  int fail_cnt;

  initial fail_cnt = 0;

  // -------------------------------------------------------------------
  // result port
  // -------------------------------------------------------------------
  res_stable: assert property (@(posedge clk) disable iff (!arst_n)
    res_req && $past(res_req) |-> $stable(res))
    else begin
      fail_cnt++;
      $error("res changed while res_req was high");
    end

  // req held until ack is seen
  res_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
    res_req && !res_ack |=> res_req)
    else begin
      fail_cnt++;
      $error("res_req fell before res_ack rose");
    end

  // -------------------------------------------------------------------
  // job port
  // -------------------------------------------------------------------
  job_ack_hold: assert property (@(posedge clk) disable iff (!arst_n)
    job_ack && job_req |=> job_ack)
    else begin
      fail_cnt++;
      $error("job_ack fell while job_req was high");
    end

  // job_ack opens only after the requested lane took the job
  job_ack_after_lane: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(job_ack) |-> $past(|(lane_req & lane_ack)))
    else begin
      fail_cnt++;
      $error("job_ack rose before any lane acked the job");
    end

  lane_req_one: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(lane_req))
    else begin
      fail_cnt++;
      $error("more than one lane request raised");
    end

  // reset values, from the second reset edge on and just after release
  reset_low: assert property (@(posedge clk)
    $past(!arst_n) |-> !job_ack && !res_req)
    else begin
      fail_cnt++;
      $error("job_ack or res_req high around reset");
    end

endmodule

`default_nettype wire

// File: testbench/trav_model.svh
/*
  reference math for the traversal lane, included into the testbench
  wide integer divide, truncating toward zero, clipped to the fix_t range
  split - origin is clipped before the divide, as the lane does
*/
`ifndef TRAV_MODEL_SVH
`define TRAV_MODEL_SVH

// split - origin, clipped
function automatic kd_trav_pkg::fix_t model_diff(input kd_trav_pkg::fix_t split,
                                                 input kd_trav_pkg::fix_t origin);
  longint d;
  d = longint'(split) - longint'(origin);
  if (d > longint'(kd_trav_pkg::FIX_MAX)) return kd_trav_pkg::FIX_MAX;
  if (d < longint'(kd_trav_pkg::FIX_MIN)) return kd_trav_pkg::FIX_MIN;
  return kd_trav_pkg::fix_t'(d);
endfunction

// Q16.16 quotient, FIX_MAX for a zero divisor
function automatic kd_trav_pkg::fix_t model_tmid(input kd_trav_pkg::fix_t num,
                                                 input kd_trav_pkg::fix_t den);
  longint q;
  if (den == 0) return kd_trav_pkg::FIX_MAX;
  q = (longint'(num) <<< kd_trav_pkg::FIX_FRAC) / longint'(den);
  if (q > longint'(kd_trav_pkg::FIX_MAX)) return kd_trav_pkg::FIX_MAX;
  if (q < longint'(kd_trav_pkg::FIX_MIN)) return kd_trav_pkg::FIX_MIN;
  return kd_trav_pkg::fix_t'(q);
endfunction

// full expected result of one job
function automatic kd_trav_pkg::trav_res_t model_result(input kd_trav_pkg::trav_job_t j);
  kd_trav_pkg::trav_res_t r;
  logic                   near_lo;
  r.tag      = j.tag;
  r.dir_zero = (j.dir == 0);
  r.t_min    = j.t_min;
  r.t_max    = j.t_max;
  r.t_mid    = model_tmid(model_diff(j.split, j.origin), j.dir);
  // on the plane, the direction decides
  near_lo = (j.origin < j.split) || ((j.origin == j.split) && (j.dir <= 0));
  if (r.dir_zero || r.t_mid < 0 || r.t_mid >= j.t_max)
    r.tcase = near_lo ? kd_trav_pkg::ONLY_LOW : kd_trav_pkg::ONLY_HIGH;
  else if (r.t_mid <= j.t_min)
    r.tcase = near_lo ? kd_trav_pkg::ONLY_HIGH : kd_trav_pkg::ONLY_LOW;
  else
    r.tcase = near_lo ? kd_trav_pkg::LO_THEN_HI : kd_trav_pkg::HI_THEN_LO;
  return r;
endfunction

`endif

// File: testbench/tb_kd_trav.sv
/*
  testbench for kd_trav_top
  directed jobs for every case, then a stalled burst, then random jobs
  expected results come from trav_model.svh, keyed by tag
  a tag is reused only after its result came back
*/
`timescale 1ns/1ps
`default_nettype none

module tb_kd_trav;

  localparam int N_JOBS       = 64;
  localparam int N_DIRECTED   = 12;
  localparam int STALL_CYCLES = 200;

  logic                   clk;
  logic                   arst_n;
  logic                   job_req;
  kd_trav_pkg::trav_job_t job;
  logic                   res_ack;
  logic                   job_ack;
  logic                   res_req;
  kd_trav_pkg::trav_res_t res;

  // scoreboard with one slot per tag
  kd_trav_pkg::trav_res_t exp_res  [16];
  string                  exp_name [16];
  logic [15:0]            in_flight = '0;
  int                     received  = 0;
  int                     acked     = 0;
  int                     errors    = 0;
  logic                   stall     = 1'b0;
  logic [31:0]            lfsr      = 32'hb964;

  kd_trav_top UUT (
    .clk     (clk),
    .arst_n  (arst_n),
    .job_req (job_req),
    .job     (job),
    .res_ack (res_ack),
    .job_ack (job_ack),
    .res_req (res_req),
    .res     (res)
  );

  bind kd_trav_top kd_trav_props u_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .job_req   (job_req),
    .job_ack   (job_ack),
    .res_req   (res_req),
    .res_ack   (res_ack),
    .res       (res),
    .lane_req  (lane_req),
    .lane_ack  (lane_ack)
  );

  `include "trav_model.svh"

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // -------------------------------------------------------------------
  // random source stepped once per bit
  // -------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // n-bit two's complement value sign extended to 32 bits
  function automatic kd_trav_pkg::fix_t rand_signed(input int n);
    return $signed(rand_bits(n) << (32 - n)) >>> (32 - n);
  endfunction

  function automatic kd_trav_pkg::fix_t fx(input int whole);
    return kd_trav_pkg::fix_t'(whole) <<< kd_trav_pkg::FIX_FRAC;
  endfunction

  // -------------------------------------------------------------------
  // stimulus
  // -------------------------------------------------------------------
  task automatic directed_job(input int k, output kd_trav_pkg::trav_job_t j,
                              output string name);
    j       = '0;
    j.t_max = fx(5);
    j.split = fx(2);
    j.dir   = fx(1);
    case (k)
      0: name = "case_lo_then_hi";
      1: begin
        j.origin = fx(4);
        j.dir    = fx(-1);
        name     = "case_hi_then_lo";
      end
      2: begin
        j.dir = fx(-1);
        name  = "case_moving_away";
      end
      3: begin
        j.t_min = fx(3);
        name    = "case_far_only";
      end
      // origin on the plane
      4: begin
        j.origin = fx(2);
        j.dir    = -32'sh8000;
        name     = "case_on_plane_down";
      end
      5: begin
        j.origin = fx(2);
        j.dir    = 32'sh8000;
        name     = "case_on_plane_up";
      end
      6: begin
        j.split = fx(10);
        name    = "case_past_exit";
      end
      7: begin
        j.origin = 32'sh0000_4ccd;
        j.split  = 32'sh0001_b333;
        j.dir    = 32'shffff_4ccd;
        name     = "tmid_negative_frac";
      end
      8: begin
        j.origin = 32'shfffe_c000;
        j.split  = 32'sh0003_1999;
        j.dir    = 32'sh0000_4ccd;
        j.t_max  = fx(20);
        name     = "tmid_frac";
      end
      9: begin
        j.origin = fx(-30000);
        j.split  = fx(30000);
        j.dir    = 32'sh1;
        name     = "tmid_sat_max";
      end
      10: begin
        j.origin = fx(-30000);
        j.split  = fx(30000);
        j.dir    = -32'sh1;
        name     = "tmid_sat_min";
      end
      default: begin
        j.dir = '0;
        name  = "dir_zero";
      end
    endcase
  endtask

  task automatic random_job(output kd_trav_pkg::trav_job_t j);
    j        = '0;
    j.origin = rand_signed(21);
    j.split  = rand_signed(21);
    j.dir    = rand_signed(18);
    j.t_min  = rand_bits(19);
    j.t_max  = j.t_min + kd_trav_pkg::fix_t'(rand_bits(21));
  endtask

  // one four-phase job transfer
  task automatic send_job(input kd_trav_pkg::trav_job_t j, input string name);
    while (in_flight[j.tag]) @(posedge clk);
    exp_res[j.tag]   = model_result(j);
    exp_name[j.tag]  = name;
    in_flight[j.tag] = 1'b1;
    @(posedge clk);
    job     <= j;
    job_req <= 1'b1;
    do @(posedge clk); while (!job_ack);
    acked++;
    job_req <= 1'b0;
    do @(posedge clk); while (job_ack);
    repeat (rand_bits(2)) @(posedge clk);
  endtask

  // -------------------------------------------------------------------
  // checks
  // -------------------------------------------------------------------
  task automatic check_field(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (expected === actual) else begin
      errors++;
      $display("ERROR %s %s: expected %h, actual %h", test, field, expected, actual);
    end
  endtask

  task automatic check_result(input kd_trav_pkg::trav_res_t r);
    kd_trav_pkg::trav_res_t e;
    e = exp_res[r.tag];
    assert (in_flight[r.tag]) else begin
      errors++;
      $display("result for tag %0d arrived with no job in flight", r.tag);
    end
    if (in_flight[r.tag]) begin
      check_field(exp_name[r.tag], "tcase", e.tcase, r.tcase);
      check_field(exp_name[r.tag], "dir_zero", e.dir_zero, r.dir_zero);
      check_field(exp_name[r.tag], "t_min", e.t_min, r.t_min);
      check_field(exp_name[r.tag], "t_max", e.t_max, r.t_max);
      check_field(exp_name[r.tag], "t_mid", e.t_mid, r.t_mid);
      in_flight[r.tag] = 1'b0;
      received++;
    end
  endtask

  // result side acks after a random delay
  initial begin : receive
    kd_trav_pkg::trav_res_t r;
    wait (arst_n === 1'b1);
    forever begin
      do @(posedge clk); while (!res_req);
      r = res;
      check_result(r);
      while (stall) @(posedge clk);
      repeat (rand_bits(3)) @(posedge clk);
      res_ack <= 1'b1;
      do @(posedge clk); while (res_req);
      res_ack <= 1'b0;
    end
  end

  // burst with res_ack held off fills all lanes and the collector
  initial begin : burst
    int start;
    wait (stall);
    start = acked;
    repeat (STALL_CYCLES) @(posedge clk);
    assert (acked - start == kd_trav_pkg::N_LANES + 1) else begin
      errors++;
      $display("ERROR burst accepted: expected %0d, actual %0d",
               kd_trav_pkg::N_LANES + 1, acked - start);
    end
    stall = 1'b0;
  end

  initial begin : watchdog
    repeat (N_JOBS * 200) @(posedge clk);
    $display("timeout: results missing");
    $display("TESTBENCH FAILED");
    $finish;
  end

  // -------------------------------------------------------------------
  // main sequence
  // -------------------------------------------------------------------
  initial begin : drive
    kd_trav_pkg::trav_job_t j;
    string                  name;
    arst_n  = 1'b0;
    job_req = 1'b0;
    job     = '0;
    res_ack = 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);
    for (int n = 0; n < N_JOBS; n++) begin
      if (n < N_DIRECTED) begin
        directed_job(n, j, name);
      end else begin
        // drain before the stalled burst
        if (n == N_DIRECTED) begin
          wait (in_flight == '0);
          // last directed result fully acked before res_ack is held off
          while (res_req || res_ack) @(posedge clk);
          stall = 1'b1;
        end
        random_job(j);
        name = "random";
      end
      j.tag = kd_trav_pkg::tag_t'(n);
      send_job(j, name);
    end
    wait (received == N_JOBS);
    // the last ack closes well inside this window
    repeat (20) @(posedge clk);
    assert (!res_req) else begin
      errors++;
      $display("a result was offered after every tag had returned");
    end
    $display("summary: %0d errors, %0d assertion failures", errors, UUT.u_props.fail_cnt);
    if (errors == 0 && UUT.u_props.fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+testbench
common/kd_trav_pkg.sv
trav_math/fix_div.sv
trav_math/trav_math.sv
hdl/trav_dispatch.sv
hdl/trav_collect.sv
hdl/kd_trav_top.sv
testbench/kd_trav_properties.sv
testbench/tb_kd_trav.sv
